// File: issueCtl_defines.svh
// Global sizes and the bubble encoding for the instruction issue-control block
`ifndef ISSUECTL_DEFINES_SVH
`define ISSUECTL_DEFINES_SVH

// Width of one instruction word
`define INST_WIDTH 16

// Eight architectural registers
`define REG_IDX_WIDTH 3

// Stages after issue that may still write a register (D, X, M, W)
`define TRACK_DEPTH 4

// Bubble inserted on a stall, opcode 00001 with all other bits zero
`define NOP_INST {5'b00001, 11'b0}

`endif

// File: isaPkg.sv
// Instruction-set types, field positions and opcode classification for the issue logic
`include "issueCtl_defines.svh"

package isaPkg;

    typedef logic [`INST_WIDTH-1:0] instWord;
    typedef logic [`REG_IDX_WIDTH-1:0] regIdx;

    // Field positions inside an instruction word
    localparam int OpLo = 11;
    localparam int RsHi = 10;
    localparam int RsLo = 8;
    // Rt for R-format, Rd for loads, stores and I-format 1
    localparam int RtHi = 7;
    localparam int RtLo = 5;
    // Rd of R-format, set and BTR
    localparam int RdRHi = 4;
    localparam int RdRLo = 2;

    typedef logic [`INST_WIDTH-OpLo-1:0] opField;

    typedef enum logic [3:0] {
        opHalt,
        opNone,
        opStore,
        opStoreUpd,
        opRType,
        opSet,
        opJump,
        opJumpReg,
        opJumpLink,
        opJumpLinkReg,
        opBranch,
        opLoadImm,
        opImmRs,
        opOther
    } opGroup;

    // Sort an instruction into the group that decides its reads and writes
    function automatic opGroup classifyOp(instWord inst);
        opField op;
        opGroup grp;
        op = inst[`INST_WIDTH-1:OpLo];
        casez (op)
            5'b00000: grp = opHalt;
            // NOP, siic, RTI
            5'b00001, 5'b0001?: grp = opNone;
            5'b00100: grp = opJump;
            5'b00101: grp = opJumpReg;
            5'b00110: grp = opJumpLink;
            5'b00111: grp = opJumpLinkReg;
            5'b011??: grp = opBranch;
            5'b10000: grp = opStore;
            5'b10011: grp = opStoreUpd;
            5'b11011, 5'b11010: grp = opRType;
            5'b111??: grp = opSet;
            // LBI and SLBI
            5'b11000, 5'b10010: grp = opLoadImm;
            // I-format 1 arithmetic, shifts and LD
            5'b010??, 5'b101??, 5'b10001: grp = opImmRs;
            // BTR lands here
            default: grp = opOther;
        endcase
        return grp;
    endfunction

endpackage

// File: pipePkg.sv
// Pipeline bookkeeping types shared by the tracker, the checkers and the issue gate
`include "issueCtl_defines.svh"

package pipePkg;

    import isaPkg::*;

    // What an in-flight instruction will do to the register file and PC
    typedef struct packed {
        logic  regWrt;
        regIdx wrtReg;
        logic  isControl;
    } inflightRec;

    // Outcome of both hazard checks for the fetched instruction
    typedef struct packed {
        logic dataStall;
        logic ctrlStall;
        logic isHalt;
    } hazardFlags;

endpackage

// File: inflightTracker.sv
// Records the register write and control flag of each issued instruction through D, X, M and W
`include "issueCtl_defines.svh"

module inflightTracker
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  instWord    issuedInst,
    output inflightRec stages [`TRACK_DEPTH]
);

    opGroup     issuedGroup;
    inflightRec issuedRec;

    // Destination decode of the instruction entering decode
    always_comb begin
        issuedGroup = classifyOp(issuedInst);
        issuedRec = '0;
        case (issuedGroup)
            opRType, opSet, opOther: begin
                issuedRec.regWrt = 1'b1;
                issuedRec.wrtReg = issuedInst[RdRHi:RdRLo];
            end
            opImmRs: begin
                issuedRec.regWrt = 1'b1;
                issuedRec.wrtReg = issuedInst[RtHi:RtLo];
            end
            opStoreUpd, opLoadImm: begin
                issuedRec.regWrt = 1'b1;
                issuedRec.wrtReg = issuedInst[RsHi:RsLo];
            end
            opJumpLink, opJumpLinkReg: begin
                // Link address goes to R7
                issuedRec.regWrt = 1'b1;
                issuedRec.wrtReg = '1;
            end
            default: begin
                issuedRec.regWrt = 1'b0;
            end
        endcase

        issuedRec.isControl = issuedGroup inside {opJump, opJumpReg, opJumpLink,
                                                  opJumpLinkReg, opBranch};
    end

    // Shift every cycle, bubbles enter as empty records
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `TRACK_DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= issuedRec;
            for (int i = 1; i < `TRACK_DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

endmodule

// File: dataHazardCheck.sv
// Read-after-write check of the fetched instruction against all in-flight register writes
`include "issueCtl_defines.svh"

module dataHazardCheck
    import isaPkg::*;
    import pipePkg::*;
(
    input  instWord    fetchInst,
    input  inflightRec stages [`TRACK_DEPTH],
    output logic       dataStall
);

    opGroup fetchGroup;
    regIdx  rsIdx;
    regIdx  rtIdx;
    logic   readsRs;
    logic   readsRt;
    logic   rsHit;
    logic   rtHit;

    // Which source fields does the fetched instruction actually read
    always_comb begin
        fetchGroup = classifyOp(fetchInst);
        rsIdx = fetchInst[RsHi:RsLo];
        rtIdx = fetchInst[RtHi:RtLo];

        case (fetchGroup)
            // Stores read Rd as data, R-format and set read Rt
            opStore, opStoreUpd, opRType, opSet: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            opNone, opJump, opJumpLink, opHalt: begin
                readsRs = 1'b0;
                readsRt = 1'b0;
            end
            default: begin
                readsRs = 1'b1;
                readsRt = 1'b0;
            end
        endcase
    end

    // Compare against every slot that will still write back
    always_comb begin
        rsHit = 1'b0;
        rtHit = 1'b0;
        for (int i = 0; i < `TRACK_DEPTH; i++) begin
            if (stages[i].regWrt) begin
                rsHit = rsHit | (stages[i].wrtReg == rsIdx);
                rtHit = rtHit | (stages[i].wrtReg == rtIdx);
            end
        end
    end

    assign dataStall = (readsRs && rsHit) || (readsRt && rtHit);

endmodule

// File: controlHazardCheck.sv
// Flags fetched control and halt instructions and holds issue behind unresolved control flow
`include "issueCtl_defines.svh"

module controlHazardCheck
    import isaPkg::*;
    import pipePkg::*;
(
    input  instWord    fetchInst,
    input  inflightRec stages [`TRACK_DEPTH],
    output logic       ctrlStall,
    output logic       isHalt,
    output logic       branchInstF
);

    // Control flow resolves by the end of execute
    localparam int SlotD = 0;
    localparam int SlotX = 1;

    opGroup fetchGroup;

    always_comb begin
        fetchGroup = classifyOp(fetchInst);
        branchInstF = fetchGroup inside {opJump, opJumpReg, opJumpLink,
                                         opJumpLinkReg, opBranch};
        isHalt = (fetchGroup == opHalt);
        ctrlStall = stages[SlotD].isControl || stages[SlotX].isControl;
    end

endmodule

// File: issueGate.sv
// Turns the hazard flags into the instruction issued to decode and the PC hold
`include "issueCtl_defines.svh"

module issueGate
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic       rstN,
    input  instWord    fetchInst,
    input  hazardFlags flags,
    output instWord    nextInst,
    output logic       pcNop
);

    always_comb begin
        if (!rstN) begin
            // Feed bubbles while the pipe comes out of reset
            nextInst = `NOP_INST;
            pcNop = 1'b0;
        end else begin
            pcNop = flags.dataStall || flags.ctrlStall || flags.isHalt;
            nextInst = pcNop ? `NOP_INST : fetchInst;
        end
    end

endmodule

// File: issueCtl.sv
// Issue control between fetch and decode, stalls on data and control hazards and on halt
`include "issueCtl_defines.svh"

module issueCtl
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  instWord fetchInst,
    output instWord nextInst,
    output logic    pcNop,
    output logic    branchInstF
);

    inflightRec stages [`TRACK_DEPTH];
    // Each checker drives its own fields
    wire hazardFlags flags;

    inflightTracker inflightTracker_i (
        .clk        (clk),
        .rstN       (rstN),
        .issuedInst (nextInst),
        .stages     (stages)
    );

    dataHazardCheck dataHazardCheck_i (
        .fetchInst (fetchInst),
        .stages    (stages),
        .dataStall (flags.dataStall)
    );

    controlHazardCheck controlHazardCheck_i (
        .fetchInst   (fetchInst),
        .stages      (stages),
        .ctrlStall   (flags.ctrlStall),
        .isHalt      (flags.isHalt),
        .branchInstF (branchInstF)
    );

    issueGate issueGate_i (
        .rstN      (rstN),
        .fetchInst (fetchInst),
        .flags     (flags),
        .nextInst  (nextInst),
        .pcNop     (pcNop)
    );

endmodule

// File: issueCtlTb.sv
// Table-driven self-checking testbench for the fetch-to-decode issue-control block
`include "issueCtl_defines.svh"

module issueCtlTb
    import isaPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ClkPeriod = 40;
    localparam int DriveDelay = 2;
    localparam int ResetCycles = 16;
    localparam int HaltObserveCycles = 8;
    localparam int WatchdogPerRow = 6;
    localparam int WatchdogSlack = 40;

    localparam instWord NopInst = `NOP_INST;

    // Opcodes of the instruction set
    localparam logic [4:0] CodeHalt = 5'b00000;
    localparam logic [4:0] CodeNop = 5'b00001;
    localparam logic [4:0] CodeSiic = 5'b00010;
    localparam logic [4:0] CodeJ = 5'b00100;
    localparam logic [4:0] CodeJr = 5'b00101;
    localparam logic [4:0] CodeJal = 5'b00110;
    localparam logic [4:0] CodeJalr = 5'b00111;
    localparam logic [4:0] CodeAddi = 5'b01000;
    localparam logic [4:0] CodeBeqz = 5'b01100;
    localparam logic [4:0] CodeSt = 5'b10000;
    localparam logic [4:0] CodeLd = 5'b10001;
    localparam logic [4:0] CodeStu = 5'b10011;
    localparam logic [4:0] CodeAdd = 5'b11011;
    localparam logic [4:0] CodeSeq = 5'b11100;

    typedef enum logic [1:0] {
        rowFixed,
        rowFill,
        rowHalt
    } rowKind;

    // One instruction and what the issue logic must do with it
    typedef struct packed {
        instWord    inst;
        logic [3:0] expStall;
        logic       expBranch;
        rowKind     kind;
    } stimRow;

    bit      clk;
    logic    rstN;
    instWord fetchInst;
    instWord nextInst;
    logic    pcNop;
    logic    branchInstF;

    stimRow stimTable[$];
    bit     tableReady;
    integer seed;

    issueCtl issueCtl_i (
        .clk         (clk),
        .rstN        (rstN),
        .fetchInst   (fetchInst),
        .nextInst    (nextInst),
        .pcNop       (pcNop),
        .branchInstF (branchInstF)
    );

    initial begin
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Instruction encoders for the four formats
    function automatic instWord encodeRType(logic [4:0] op, regIdx rs, regIdx rt, regIdx rd);
        return {op, rs, rt, rd, 2'b00};
    endfunction

    function automatic instWord encodeIType1(logic [4:0] op, regIdx rs, regIdx rd,
                                             logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic instWord encodeIType2(logic [4:0] op, regIdx rs, logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic instWord encodeJType(logic [4:0] op, logic [10:0] disp);
        return {op, disp};
    endfunction

    task automatic reportFailure(string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic checkValue(string sigName, string ctx, logic [31:0] expVal,
                              logic [31:0] gotVal);
        assert (gotVal === expVal) else reportFailure(
            $sformatf("ERR %s %s: expected 0x%0h, got 0x%0h", sigName, ctx, expVal, gotVal));
    endtask

    task automatic addRow(instWord inst, int expStall, logic expBranch);
        stimRow row;
        row.inst = inst;
        row.expStall = 4'(expStall);
        row.expBranch = expBranch;
        row.kind = rowFixed;
        stimTable.push_back(row);
    endtask

    // NOP or siic with random low bits, never reads or writes a register
    task automatic addFillRows(int count);
        logic [31:0] rnd;
        stimRow row;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            row.inst = {(rnd[11] ? CodeSiic : CodeNop), rnd[10:0]};
            row.expStall = 4'd0;
            row.expBranch = 1'b0;
            row.kind = rowFill;
            stimTable.push_back(row);
        end
    endtask

    task automatic addHaltRow();
        stimRow row;
        row.inst = {CodeHalt, 11'b0};
        row.expStall = 4'd0;
        row.expBranch = 1'b0;
        row.kind = rowHalt;
        stimTable.push_back(row);
    endtask

    // Stall counts follow from the writer distance (5 - d) and control distance (3 - d)
    task automatic buildTable();
        addFillRows(3);
        // R1 written, then read as Rt at distance 1, 2 and 3
        addRow(encodeRType(CodeAdd, 3'd2, 3'd3, 3'd1), 0, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd5, 3'd1, 3'd4), 4, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd2, 3'd3, 3'd1), 0, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd2, 3'd3, 3'd6), 0, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd5, 3'd1, 3'd4), 3, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd2, 3'd3, 3'd1), 0, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd2, 3'd3, 3'd6), 0, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd3, 3'd2, 3'd7), 0, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd5, 3'd1, 3'd4), 2, 1'b0);
        addFillRows(3);
        // Store data register comes straight from the load
        addRow(encodeIType1(CodeLd, 3'd5, 3'd2, 5'h04), 0, 1'b0);
        addRow(encodeIType1(CodeSt, 3'd6, 3'd2, 5'h08), 4, 1'b0);
        addRow(encodeIType1(CodeAddi, 3'd0, 3'd3, 5'h05), 0, 1'b0);
        // Control flow
        addRow(encodeJType(CodeJ, 11'h012), 0, 1'b1);
        addRow(encodeRType(CodeAdd, 3'd2, 3'd6, 3'd5), 2, 1'b0);
        addRow(encodeRType(CodeAdd, 3'd0, 3'd0, 3'd4), 0, 1'b0);
        addRow(encodeIType2(CodeJr, 3'd4, 8'h10), 4, 1'b1);
        addRow(encodeJType(CodeJal, 11'h020), 2, 1'b1);
        // JALR reads the link register JAL just wrote, data stall dominates
        addRow(encodeIType2(CodeJalr, 3'd7, 8'h02), 4, 1'b1);
        addRow(encodeIType2(CodeBeqz, 3'd1, 8'hf0), 2, 1'b1);
        addRow(encodeRType(CodeSeq, 3'd0, 3'd0, 3'd6), 2, 1'b0);
        addRow(encodeIType1(CodeStu, 3'd5, 3'd0, 5'h01), 0, 1'b0);
        addFillRows(2);
        addHaltRow();
    endtask

    // Holds reset with some instruction on the fetch bus, then releases it with a NOP
    task automatic resetDut(instWord heldInst);
        rstN = 1'b0;
        fetchInst = heldInst;
        repeat (ResetCycles) begin
            @(negedge clk);
            checkValue("nextInst", "in reset", 32'(NopInst), 32'(nextInst));
            checkValue("pcNop", "in reset", 32'd0, 32'(pcNop));
            @(posedge clk);
            #DriveDelay;
        end
        fetchInst = NopInst;
        rstN = 1'b1;
        @(negedge clk);
        checkValue("nextInst", "after reset", 32'(NopInst), 32'(nextInst));
        checkValue("pcNop", "after reset", 32'd0, 32'(pcNop));
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic runRow(int idx);
        stimRow row;
        string  ctx;
        int     stallCount;
        bit     accepted;
        row = stimTable[idx];
        ctx = $sformatf("row %0d", idx);
        stallCount = 0;
        accepted = 1'b0;
        fetchInst = row.inst;
        if (row.kind == rowHalt) begin
            repeat (HaltObserveCycles) begin
                @(negedge clk);
                checkValue("pcNop", ctx, 32'd1, 32'(pcNop));
                checkValue("nextInst", ctx, 32'(NopInst), 32'(nextInst));
                checkValue("branchInstF", ctx, 32'(row.expBranch), 32'(branchInstF));
                @(posedge clk);
                #DriveDelay;
            end
        end else begin
            while (!accepted) begin
                @(negedge clk);
                checkValue("branchInstF", ctx, 32'(row.expBranch), 32'(branchInstF));
                if (pcNop) begin
                    // Fetch holds the instruction while a bubble goes out
                    stallCount++;
                    checkValue("nextInst", ctx, 32'(NopInst), 32'(nextInst));
                    assert (stallCount <= int'(row.expStall)) else reportFailure(
                        $sformatf("ERR stallCount %s: expected 0x%0h, got 0x%0h",
                                  ctx, row.expStall, stallCount));
                end else begin
                    checkValue("nextInst", ctx, 32'(row.inst), 32'(nextInst));
                    checkValue("stallCount", ctx, 32'(row.expStall), 32'(stallCount));
                    accepted = 1'b1;
                end
                @(posedge clk);
                #DriveDelay;
            end
        end
    endtask

    initial begin
        wait (tableReady);
        repeat (stimTable.size() * WatchdogPerRow + WatchdogSlack) @(posedge clk);
        reportFailure("Timeout, the run did not finish in the expected number of clock cycles");
    end

    initial begin
        rstN = 1'b0;
        fetchInst = NopInst;
        seed = 32'h2454_f046;
        buildTable();
        tableReady = 1'b1;

        resetDut(encodeRType(CodeAdd, 3'd1, 3'd2, 3'd3));
        for (int i = 0; i < stimTable.size(); i++) begin
            runRow(i);
        end
        // Halt is still on the fetch bus when reset comes back
        resetDut(fetchInst);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: issueCtl.f
+incdir+.
isaPkg.sv
pipePkg.sv
inflightTracker.sv
dataHazardCheck.sv
controlHazardCheck.sv
issueGate.sv
issueCtl.sv
issueCtlTb.sv

// File: Makefile
# Verilator build and run for the issue-control testbench

VERILATOR ?= verilator
TOP       ?= issueCtlTb
FILELIST  ?= issueCtl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' $(FILELIST)) issueCtl_defines.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
